// File: files.f
rtl/spi_link_pkg.sv
rtl/reg_map_pkg.sv
rtl/spi_slave_port.sv
rtl/cmd_decode.sv
rtl/reg_execute.sv
rtl/resp_build.sv
rtl/spi_reg_top.sv
dv/spi_reg_tb.sv

// File: dv/spi_reg_tb.sv
// Testbench for the SPI register bank in SPI mode 1 (CPOL 0, CPHA 1).
// The SPI master runs SCK at a half-period of 10 aclk cycles and drives
// every pin on the falling aclk edge.
// Expected byte-1 values come from a register model that is updated
// row by row while the stimulus table is built.

`timescale 1ns/1ps

module spi_reg_tb import spi_link_pkg::*; import reg_map_pkg::*; ();

    localparam int half_period = 10;
    localparam int oe_timeout  = 20;

    typedef enum logic [2:0] {k_read, k_write, k_illegal, k_abort, k_long} kind_t;

    typedef struct packed {
        kind_t      kind;
        reg_addr_t  addr;
        reg_value_t data;
        reg_value_t exp_val;
    } row_t;

    logic aclk;
    logic aresetn;
    logic sck;
    logic ss_n;
    logic mosi;
    logic miso;
    logic miso_oe;

    row_t        table_q[$];
    reg_value_t  model [reg_count];
    logic [31:0] lfsr_state;
    int          error_count;

    spi_reg_top #(
        .clock_polarity (1'b0),
        .clock_phase    (1'b1)
    ) dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .sck     (sck),
        .ss_n    (ss_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    always #4 aclk = ~aclk;

    // --------------------
    // Random data
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic reg_value_t lfsr_byte();
        reg_value_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    // --------------------
    // Checks
    // --------------------

    task automatic check_value(input string name, input reg_value_t got, input reg_value_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t ns %s: got %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    function automatic string kind_text(input kind_t kind);
        case (kind)
            k_read:    return "read";
            k_write:   return "write";
            k_illegal: return "illegal";
            k_abort:   return "abort";
            default:   return "long";
        endcase
    endfunction

    // --------------------
    // Stimulus table
    // --------------------

    task automatic add_row(input kind_t kind, input reg_addr_t addr, input reg_value_t data);
        row_t row;
        row.kind    = kind;
        row.addr    = addr;
        row.data    = data;
        row.exp_val = (kind == k_illegal) ? illegal_resp : model[addr];
        // Only completed legal writes to RW addresses land and count
        if ((kind == k_write || kind == k_long) && addr != count_reg_addr) begin
            model[addr]           = data;
            model[count_reg_addr] = model[count_reg_addr] + 1'b1;
        end
        table_q.push_back(row);
    endtask

    task automatic build_table();
        for (int a = 0; a < reg_count; a++) begin
            add_row(k_read, reg_addr_t'(a), '0);
        end
        for (int a = 0; a < reg_count - 1; a++) begin
            add_row(k_write, reg_addr_t'(a), lfsr_byte());
            add_row(k_read, reg_addr_t'(a), '0);
        end
        add_row(k_read, count_reg_addr, '0);
        add_row(k_write, count_reg_addr, lfsr_byte());
        add_row(k_read, count_reg_addr, '0);
        add_row(k_illegal, 4'd3, lfsr_byte());
        add_row(k_read, 4'd3, '0);
        add_row(k_read, count_reg_addr, '0);
        add_row(k_abort, 4'd5, lfsr_byte());
        add_row(k_read, 4'd5, '0);
        add_row(k_long, 4'd7, lfsr_byte());
        add_row(k_read, 4'd7, '0);
        add_row(k_read, count_reg_addr, '0);
    endtask

    // --------------------
    // SPI master
    // --------------------

    task automatic half_wait();
        repeat (half_period) @(negedge aclk);
    endtask

    task automatic begin_frame();
        int n;
        ss_n = 1'b0;
        n    = 0;
        while (!miso_oe && n < oe_timeout) begin
            @(negedge aclk);
            n++;
        end
        if (!miso_oe) begin
            $display("Timeout: miso_oe stayed low %0d cycles after ss_n fell", oe_timeout);
            $display("Errors found");
            $finish;
        end
        half_wait();
    endtask

    // MISO must be released once select is gone
    task automatic end_frame();
        ss_n = 1'b1;
        mosi = 1'b0;
        half_wait();
        check_bit("miso_oe after deselect", miso_oe, 1'b0);
        half_wait();
    endtask

    // Output on the rising SCK edge, capture on the falling one
    task automatic shift_byte(input spi_word_t tx, output spi_word_t rx);
        rx = '0;
        for (int i = spi_word_bits - 1; i >= 0; i--) begin
            sck  = 1'b1;
            mosi = tx[i];
            half_wait();
            rx[i] = miso;
            sck   = 1'b0;
            half_wait();
        end
    endtask

    task automatic run_row(input int idx, input row_t row);
        spi_word_t cmd;
        spi_word_t r0;
        spi_word_t r1;
        spi_word_t rx;
        int        errors_before;
        errors_before = error_count;
        case (row.kind)
            k_read:    cmd = {1'b0, 3'b000, row.addr};
            k_illegal: cmd = {1'b1, 3'b101, row.addr};
            default:   cmd = {1'b1, 3'b000, row.addr};
        endcase
        begin_frame();
        shift_byte(cmd, r0);
        check_word("miso byte 0", r0, '0);
        if (row.kind != k_abort) begin
            shift_byte(spi_word_t'(row.data), r1);
            check_value("miso byte 1", reg_value_t'(r1), row.exp_val);
        end
        if (row.kind == k_long) begin
            for (int i = 0; i < 2; i++) begin
                shift_byte(~spi_word_t'(row.data), rx);
                check_word("miso extra byte", rx, '0);
            end
        end
        end_frame();
        $display("test %0d %s addr %0d: %s", idx, kind_text(row.kind), row.addr,
                 (error_count == errors_before) ? "pass" : "FAIL");
    endtask

    initial begin
        aclk        = 1'b0;
        aresetn     = 1'b0;
        sck         = 1'b0;
        ss_n        = 1'b1;
        mosi        = 1'b0;
        lfsr_state  = 32'h8c6c3d95;
        error_count = 0;
        for (int a = 0; a < reg_count; a++) begin
            model[a] = '0;
        end
        build_table();
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        half_wait();
        for (int i = 0; i < table_q.size(); i++) begin
            run_row(i, table_q[i]);
        end
        $display("tests %0d, errors %0d", table_q.size(), error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rtl/spi_reg_top.sv
// SPI register bank top level, slave only.
// Clock polarity and phase select the SPI mode of the port.
// SCK half-period must be at least 8 aclk periods.
// MISO is valid only while miso_oe is high.

`timescale 1ns/1ps

module spi_reg_top import spi_link_pkg::*; import reg_map_pkg::*; #(
    parameter bit clock_polarity = 1'b0,
    parameter bit clock_phase    = 1'b1
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic sck,
    input  logic ss_n,
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);

    spi_word_t  rx_data;
    logic       rx_valid;
    logic       rx_ready;
    spi_word_t  tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       frame_active;

    logic       lookup_req;
    logic       lookup_illegal;
    reg_addr_t  lookup_addr;
    logic       write_req;
    reg_addr_t  write_addr;
    reg_value_t write_data;
    reg_value_t lookup_value;
    logic       lookup_done;

    spi_slave_port #(
        .clock_polarity (clock_polarity),
        .clock_phase    (clock_phase)
    ) u_port (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .sck          (sck),
        .ss_n         (ss_n),
        .mosi         (mosi),
        .miso         (miso),
        .miso_oe      (miso_oe),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .frame_active (frame_active)
    );

    cmd_decode u_decode (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .frame_active   (frame_active),
        .lookup_req     (lookup_req),
        .lookup_illegal (lookup_illegal),
        .lookup_addr    (lookup_addr),
        .write_req      (write_req),
        .write_addr     (write_addr),
        .write_data     (write_data)
    );

    reg_execute u_execute (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .lookup_req     (lookup_req),
        .lookup_illegal (lookup_illegal),
        .lookup_addr    (lookup_addr),
        .write_req      (write_req),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .lookup_value   (lookup_value),
        .lookup_done    (lookup_done)
    );

    resp_build u_resp (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .lookup_value (lookup_value),
        .lookup_done  (lookup_done),
        .frame_active (frame_active),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready)
    );

endmodule

// File: rtl/resp_build.sv
// Response holder between the register bank and the SPI transmit stream.
// Holds one word; it is dropped when the port takes it or the frame
// ends, so a late answer never reaches the next frame.

`timescale 1ns/1ps

module resp_build import spi_link_pkg::*; import reg_map_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  reg_value_t lookup_value,
    input  logic       lookup_done,
    input  logic       frame_active,
    output spi_word_t  tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tx_valid <= 1'b0;
        end else if (!frame_active) begin
            tx_valid <= 1'b0;
        end else if (lookup_done) begin
            tx_valid <= 1'b1;
        end else if (tx_valid && tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (lookup_done) begin
            tx_data <= spi_word_t'(lookup_value);
        end
    end

    // One lookup per frame, so the slot is always free
    a_no_resp_overwrite: assert property (@(posedge aclk) disable iff (!aresetn)
        lookup_done |-> !tx_valid);

endmodule

// File: rtl/reg_execute.sv
// Register bank: fifteen RW registers plus the write counter at the
// last address. Writes to the counter address are dropped and not
// counted. Lookups answer one cycle after the request.

`timescale 1ns/1ps

module reg_execute import reg_map_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       lookup_req,
    input  logic       lookup_illegal,
    input  reg_addr_t  lookup_addr,
    input  logic       write_req,
    input  reg_addr_t  write_addr,
    input  reg_value_t write_data,
    output reg_value_t lookup_value,
    output logic       lookup_done
);

    reg_value_t rw_regs [reg_count-1];
    reg_value_t write_count;
    logic       write_accept;

    assign write_accept = write_req && (write_addr != count_reg_addr);

    // --------------------
    // Writes
    // --------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < reg_count - 1; i++) begin
                rw_regs[i] <= '0;
            end
            write_count <= '0;
        end else if (write_accept) begin
            rw_regs[write_addr] <= write_data;
            // Wraps modulo 256
            write_count <= write_count + 1'b1;
        end
    end

    // --------------------
    // Lookups
    // --------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            lookup_done <= 1'b0;
        end else begin
            lookup_done <= lookup_req;
        end
    end

    always_ff @(posedge aclk) begin
        if (lookup_req) begin
            if (lookup_illegal) begin
                lookup_value <= illegal_resp;
            end else if (lookup_addr == count_reg_addr) begin
                lookup_value <= write_count;
            end else begin
                lookup_value <= rw_regs[lookup_addr];
            end
        end
    end

endmodule

// File: rtl/cmd_decode.sv
// Frame decoder. Byte 0 is the command, byte 1 the data, later bytes
// are dropped. A frame that ends before byte 1 writes nothing.
// Consumes every word at once, so rx_ready is tied high.

`timescale 1ns/1ps

module cmd_decode import spi_link_pkg::*; import reg_map_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  spi_word_t  rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,
    input  logic       frame_active,
    output logic       lookup_req,
    output logic       lookup_illegal,
    output reg_addr_t  lookup_addr,
    output logic       write_req,
    output reg_addr_t  write_addr,
    output reg_value_t write_data
);

    decode_state_t state;
    logic          cmd_write;

    assign rx_ready = 1'b1;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state          <= decode_idle;
            cmd_write      <= 1'b0;
            lookup_req     <= 1'b0;
            lookup_illegal <= 1'b0;
            write_req      <= 1'b0;
        end else begin
            lookup_req <= 1'b0;
            write_req  <= 1'b0;
            if (!frame_active) begin
                state     <= decode_idle;
                cmd_write <= 1'b0;
            end else if (rx_valid) begin
                case (state)
                    decode_idle: begin
                        lookup_req     <= 1'b1;
                        lookup_illegal <= |rx_data[cmd_rsvd_msb:cmd_rsvd_lsb];
                        // Illegal commands never write
                        cmd_write      <= rx_data[cmd_write_bit]
                                          && !(|rx_data[cmd_rsvd_msb:cmd_rsvd_lsb]);
                        state          <= decode_await_data;
                    end
                    decode_await_data: begin
                        write_req <= cmd_write;
                        state     <= decode_drain;
                    end
                    default: begin
                        state <= decode_drain;
                    end
                endcase
            end
        end
    end

    // Address and data payload
    always_ff @(posedge aclk) begin
        if (frame_active && rx_valid) begin
            if (state == decode_idle) begin
                lookup_addr <= rx_data[reg_addr_width-1:0];
            end
            if (state == decode_await_data) begin
                write_addr <= lookup_addr;
                write_data <= reg_value_t'(rx_data);
            end
        end
    end

    a_req_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
        !(write_req && lookup_req));

endmodule

// File: rtl/spi_slave_port.sv
// SPI slave port with valid/ready streams on the aclk side.
// SCK, SS_n and MOSI pass through two sync flops; SCK gets a third for
// edge detection. SCK half-period must be several aclk periods long.
// rx_valid is a one-cycle pulse per word and expects rx_ready to keep up.
// With no tx word offered at load time the port shifts out zero.

`timescale 1ns/1ps

module spi_slave_port import spi_link_pkg::*; #(
    parameter bit clock_polarity = 1'b0,
    parameter bit clock_phase    = 1'b1
) (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      sck,
    input  logic      ss_n,
    input  logic      mosi,
    output logic      miso,
    output logic      miso_oe,
    output spi_word_t rx_data,
    output logic      rx_valid,
    input  logic      rx_ready,
    input  spi_word_t tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,
    output logic      frame_active
);

    // --------------------
    // Pin synchronizers
    // --------------------

    logic [1:0] sck_sync;
    logic [1:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sck_d;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sck_sync <= {2{clock_polarity}};
            ss_sync  <= {2{spi_ss_inactive}};
            sck_d    <= clock_polarity;
        end else begin
            sck_sync <= {sck_sync[0], sck};
            ss_sync  <= {ss_sync[0], ss_n};
            sck_d    <= sck_sync[1];
        end
    end

    always_ff @(posedge aclk) begin
        mosi_sync <= {mosi_sync[0], mosi};
    end

    assign frame_active = !ss_sync[1];

    // Select drives the output enable directly, no sync delay
    assign miso_oe = !ss_n;

    // --------------------
    // SCK edges
    // --------------------

    logic sck_rise;
    logic sck_fall;
    logic capture_edge;
    logic output_edge;

    assign sck_rise = sck_sync[1] && !sck_d && frame_active;
    assign sck_fall = !sck_sync[1] && sck_d && frame_active;

    // Modes 1 and 2 capture on the falling edge
    assign capture_edge = (clock_phase ^ clock_polarity) ? sck_fall : sck_rise;
    assign output_edge  = (clock_phase ^ clock_polarity) ? sck_rise : sck_fall;

    // --------------------
    // Receive
    // --------------------

    spi_bitcnt_t rx_bitcnt;
    spi_word_t   rx_shift;
    logic        rx_word_done;

    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            rx_bitcnt <= '0;
        end else if (capture_edge) begin
            rx_bitcnt <= rx_bitcnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (capture_edge) begin
            rx_shift <= {rx_shift[spi_word_bits-2:0], mosi_sync[1]};
        end
    end

    assign rx_word_done = capture_edge && (rx_bitcnt == spi_last_bit);

    always_ff @(posedge aclk) begin
        if (rx_word_done) begin
            rx_data <= {rx_shift[spi_word_bits-2:0], mosi_sync[1]};
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rx_valid <= 1'b0;
        end else if (rx_word_done) begin
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

    // Overrun: the consumer must take each word before the next one lands
    a_rx_no_overrun: assert property (@(posedge aclk) disable iff (!aresetn)
        !(rx_word_done && rx_valid && !rx_ready));

    // --------------------
    // Transmit
    // --------------------

    spi_bitcnt_t tx_bitcnt;
    spi_word_t   tx_shift;
    logic        tx_load;

    always_ff @(posedge aclk) begin
        if (!aresetn || !frame_active) begin
            tx_bitcnt <= '0;
        end else if (output_edge) begin
            tx_bitcnt <= tx_bitcnt + 1'b1;
        end
    end

    assign miso = tx_shift[spi_word_bits-1];

    generate
        if (clock_phase) begin : g_phase1

            // First output edge of each word presents the MSB
            assign tx_load  = output_edge && (tx_bitcnt == '0);
            assign tx_ready = tx_load;

            always_ff @(posedge aclk) begin
                if (!aresetn || !frame_active) begin
                    tx_shift <= {spi_word_bits{spi_idle_miso}};
                end else if (tx_load) begin
                    tx_shift <= tx_valid ? tx_data : {spi_word_bits{spi_idle_miso}};
                end else if (output_edge) begin
                    tx_shift <= {tx_shift[spi_word_bits-2:0], spi_idle_miso};
                end
            end

        end else begin : g_phase0

            typedef enum logic {tx_empty, tx_held} tx_state_t;

            tx_state_t tx_state;
            logic      frame_active_d;
            logic      frame_end;

            // MSB must sit on MISO before the first capture edge
            assign tx_load   = output_edge && (tx_bitcnt == spi_last_bit);
            assign frame_end = frame_active_d && !frame_active;
            assign tx_ready  = ((tx_state == tx_empty) && !frame_active) || tx_load;

            always_ff @(posedge aclk) begin
                if (!aresetn) begin
                    tx_state       <= tx_empty;
                    frame_active_d <= 1'b0;
                end else begin
                    frame_active_d <= frame_active;
                    if (tx_ready && tx_valid) begin
                        tx_state <= tx_held;
                    end else if (frame_end || tx_load) begin
                        tx_state <= tx_empty;
                    end
                end
            end

            always_ff @(posedge aclk) begin
                if (!aresetn) begin
                    tx_shift <= {spi_word_bits{spi_idle_miso}};
                end else if (tx_ready && tx_valid) begin
                    tx_shift <= tx_data;
                end else if (tx_load || frame_end) begin
                    tx_shift <= {spi_word_bits{spi_idle_miso}};
                end else if (output_edge) begin
                    tx_shift <= {tx_shift[spi_word_bits-2:0], spi_idle_miso};
                end
            end

        end
    endgenerate

endmodule

// File: rtl/reg_map_pkg.sv
// Register protocol definitions.
// Command byte: bit 7 write flag, bits 6..4 reserved (must be zero),
// bits 3..0 register address. Address 15 is the read-only write counter.

package reg_map_pkg;

    // --------------------
    // Register bank
    // --------------------

    localparam int unsigned reg_addr_width  = 4;
    localparam int unsigned reg_value_width = 8;
    localparam int unsigned reg_count       = 2 ** reg_addr_width;

    typedef logic [reg_addr_width-1:0]  reg_addr_t;
    typedef logic [reg_value_width-1:0] reg_value_t;

    // Last address holds the accepted-write counter
    localparam reg_addr_t count_reg_addr = reg_addr_t'(reg_count - 1);

    // --------------------
    // Command fields
    // --------------------

    localparam int unsigned cmd_write_bit = 7;
    localparam int unsigned cmd_rsvd_msb  = 6;
    localparam int unsigned cmd_rsvd_lsb  = 4;

    // Byte 1 response to a command with reserved bits set
    localparam reg_value_t illegal_resp = 8'hee;

    // --------------------
    // Decoder FSM
    // --------------------

    typedef enum logic [1:0] {
        decode_idle,
        decode_await_data,
        decode_drain
    } decode_state_t;

endpackage

// File: rtl/spi_link_pkg.sv
// SPI link definitions shared by the port and its users.
// The word width is fixed at 8 bits by the register protocol.
// Words travel MSB first in both directions.

package spi_link_pkg;

    // --------------------
    // Word geometry
    // --------------------

    localparam int unsigned spi_word_bits = 8;

    // One SPI word on MOSI or MISO
    typedef logic [spi_word_bits-1:0] spi_word_t;

    // Bit position inside a word, wraps after the last bit
    typedef logic [$clog2(spi_word_bits)-1:0] spi_bitcnt_t;

    // Count value on the last bit of a word
    localparam spi_bitcnt_t spi_last_bit = spi_bitcnt_t'(spi_word_bits - 1);

    // --------------------
    // Idle levels
    // --------------------

    // MISO level when no word is loaded
    localparam logic spi_idle_miso = 1'b0;

    // Deasserted level of the active-low select
    localparam logic spi_ss_inactive = 1'b1;

endpackage
